// ==== common/awe_settings.svh ====
`ifndef AWE_SETTINGS_SVH
`define AWE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Row-buffer sizing
////////////////////////////////////////////////////////////

// Bits per pixel word
`define AWE_PIXEL_WIDTH 18

// Column index width; each bank half holds 2^AWE_COL_WIDTH words
`define AWE_COL_WIDTH 5

// Pixel banks in the window unit
`define AWE_BANKS 4

`endif

// ==== common/awe_data_pkg.sv ====
package awe_data_pkg;

    `include "awe_settings.svh"

    ////////////////////////////////////////////////////////////
    // Pixel and address formats
    ////////////////////////////////////////////////////////////

    localparam int NUM_BANKS = `AWE_BANKS;

    typedef logic [`AWE_PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [`AWE_COL_WIDTH-1:0]   col_t;

    // Half bit picks the upper or lower row slot of a bank
    typedef struct packed {
        logic half;
        col_t col;
    } bank_addr_t;

    typedef bank_addr_t [NUM_BANKS-1:0] bank_addr_vec_t;

    // One word from the sequencer
    typedef struct packed {
        logic row_sel;
        col_t col_even;
        col_t col_odd;
    } seq_word_t;

    // p0 comes from bank 0
    typedef struct packed {
        pixel_t p3;
        pixel_t p2;
        pixel_t p1;
        pixel_t p0;
    } pixel_quad_t;

endpackage

// ==== common/awe_ctrl_pkg.sv ====
package awe_ctrl_pkg;

    `include "awe_settings.svh"

    ////////////////////////////////////////////////////////////
    // Control types
    ////////////////////////////////////////////////////////////

    // Operating mode from the window controller
    typedef enum logic [1:0] {
        MODE_IDLE   = 2'd0,
        MODE_PRIME  = 2'd1,
        MODE_ACTIVE = 2'd2
    } mode_t;

    // Source of a bank's write data
    typedef enum logic {
        SRC_PIXEL = 1'b0,
        SRC_SAVED = 1'b1
    } wr_src_t;

    // Write command for one bank
    typedef struct packed {
        logic                   en;
        awe_data_pkg::bank_addr_t addr;
        wr_src_t                src;
    } bank_wr_t;

    typedef bank_wr_t [`AWE_BANKS-1:0] bank_wr_vec_t;

    // Odd pair is banks 1 and 3, even pair is banks 0 and 2
    typedef enum logic {
        SAVE_ODD_PAIR  = 1'b0,
        SAVE_EVEN_PAIR = 1'b1
    } save_sel_t;

endpackage

// ==== logic/pixel_ram.sv ====
`timescale 1ns/1ps

`include "awe_settings.svh"

module pixel_ram (
    input  logic                      clk,
    input  logic                      wr_en,
    input  awe_data_pkg::bank_addr_t  wr_addr,
    input  awe_data_pkg::pixel_t      wr_data,
    input  logic                      rd_en,
    input  awe_data_pkg::bank_addr_t  rd_addr,
    output awe_data_pkg::pixel_t      rd_data
);

    import awe_data_pkg::*;

    // Two halves of one row each
    localparam int DEPTH = 2 * (1 << `AWE_COL_WIDTH);

    pixel_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read holds its value between strobes
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== rowbuf/rowbuf_addr_decode.sv ====
`timescale 1ns/1ps

module rowbuf_addr_decode (
    input  awe_ctrl_pkg::mode_t           mode,
    input  logic [1:0]                    gray_code,
    input  logic [1:0]                    prime_row,
    input  awe_data_pkg::col_t            prime_col,
    input  awe_data_pkg::col_t            num_cols,
    input  logic                          pixel_valid,
    input  awe_data_pkg::seq_word_t       seq,
    input  logic                          seq_valid,
    input  logic                          shift,
    input  awe_data_pkg::col_t            shift_col,
    output awe_ctrl_pkg::bank_wr_vec_t    wr_cmd,
    output awe_data_pkg::bank_addr_vec_t  rd_addr,
    output logic                          rd_en,
    output awe_ctrl_pkg::save_sel_t       save_sel
);

    import awe_data_pkg::*;
    import awe_ctrl_pkg::*;

    logic    gray_par;
    logic    prime_ok;
    wr_src_t src_even_banks;
    wr_src_t src_odd_banks;

    function automatic bank_wr_t make_wr(logic half, col_t col, wr_src_t src);
        return '{en: 1'b1, addr: '{half: half, col: col}, src: src};
    endfunction

    assign gray_par = gray_code[0] ^ gray_code[1];
    assign prime_ok = (mode == MODE_PRIME) && pixel_valid && (prime_col <= num_cols);

    // Incoming row lands in the pair the gray parity names
    assign src_even_banks = gray_par ? SRC_PIXEL : SRC_SAVED;
    assign src_odd_banks  = gray_par ? SRC_SAVED : SRC_PIXEL;

    ////////////////////////////////////////////////////////////
    // Write commands
    ////////////////////////////////////////////////////////////
    always_comb begin
        wr_cmd = '0;
        if (prime_ok) begin
            case (prime_row)
                2'd0: begin
                    for (int b = 0; b < NUM_BANKS; b++) begin
                        wr_cmd[b] = make_wr(1'b0, prime_col, SRC_PIXEL);
                    end
                end
                2'd1: begin
                    wr_cmd[1] = make_wr(1'b1, prime_col, SRC_PIXEL);
                    wr_cmd[3] = make_wr(1'b1, prime_col, SRC_PIXEL);
                end
                2'd2: begin
                    wr_cmd[0] = make_wr(1'b1, prime_col, SRC_PIXEL);
                    wr_cmd[2] = make_wr(1'b1, prime_col, SRC_PIXEL);
                end
                default: wr_cmd = '0;
            endcase
        end else if (mode == MODE_ACTIVE && shift) begin
            wr_cmd[0] = make_wr(1'b0, shift_col, src_even_banks);
            wr_cmd[2] = make_wr(1'b0, shift_col, src_even_banks);
            wr_cmd[1] = make_wr(1'b0, shift_col, src_odd_banks);
            wr_cmd[3] = make_wr(1'b0, shift_col, src_odd_banks);
        end
    end

    ////////////////////////////////////////////////////////////
    // Read addresses
    ////////////////////////////////////////////////////////////
    assign rd_en      = (mode == MODE_ACTIVE) && seq_valid;
    assign rd_addr[0] = '{half: seq.row_sel ^ gray_code[0], col: seq.col_even};
    assign rd_addr[2] = '{half: seq.row_sel ^ gray_code[0], col: seq.col_even};
    assign rd_addr[1] = '{half: seq.row_sel ^ gray_code[1], col: seq.col_odd};
    assign rd_addr[3] = '{half: seq.row_sel ^ gray_code[1], col: seq.col_odd};

    // Save the pair that the next shift will rename
    assign save_sel = gray_par ? SAVE_EVEN_PAIR : SAVE_ODD_PAIR;

endmodule

// ==== rowbuf/rowbuf_bank_array.sv ====
`timescale 1ns/1ps

module rowbuf_bank_array (
    input  logic                          clk,
    input  awe_ctrl_pkg::bank_wr_vec_t    wr_cmd,
    input  awe_data_pkg::bank_addr_vec_t  rd_addr,
    input  logic                          rd_en,
    input  awe_data_pkg::pixel_t          pixel_in,
    input  awe_data_pkg::pixel_t          saved_even,
    input  awe_data_pkg::pixel_t          saved_odd,
    output awe_data_pkg::pixel_quad_t     bank_quad
);

    import awe_data_pkg::*;
    import awe_ctrl_pkg::*;

    pixel_t [NUM_BANKS-1:0] wr_data;
    pixel_t [NUM_BANKS-1:0] bank_dout;

    ////////////////////////////////////////////////////////////
    // Per-bank write steering and storage
    ////////////////////////////////////////////////////////////
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        pixel_t saved_px;

        // Banks 0 and 1 restore the first saved word, 2 and 3 the second
        assign saved_px   = (b < NUM_BANKS / 2) ? saved_even : saved_odd;
        assign wr_data[b] = (wr_cmd[b].src == SRC_SAVED) ? saved_px : pixel_in;

        pixel_ram u_ram (
            .clk     (clk),
            .wr_en   (wr_cmd[b].en),
            .wr_addr (wr_cmd[b].addr),
            .wr_data (wr_data[b]),
            .rd_en   (rd_en),
            .rd_addr (rd_addr[b]),
            .rd_data (bank_dout[b])
        );
    end

    ////////////////////////////////////////////////////////////
    // Gather bank outputs
    ////////////////////////////////////////////////////////////
    assign bank_quad.p0 = bank_dout[0];
    assign bank_quad.p1 = bank_dout[1];
    assign bank_quad.p2 = bank_dout[2];
    assign bank_quad.p3 = bank_dout[3];

endmodule

// ==== rowbuf/rowbuf_result.sv ====
`timescale 1ns/1ps

module rowbuf_result (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rd_en,
    input  logic                       save,
    input  awe_ctrl_pkg::save_sel_t    save_sel,
    input  awe_data_pkg::pixel_quad_t  bank_quad,
    output awe_data_pkg::pixel_quad_t  pixel_out,
    output logic                       pixel_out_valid,
    output awe_data_pkg::pixel_t       saved_even,
    output awe_data_pkg::pixel_t       saved_odd
);

    import awe_ctrl_pkg::*;

    ////////////////////////////////////////////////////////////
    // Output valid
    ////////////////////////////////////////////////////////////

    // Bank read data arrives one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            pixel_out_valid <= 1'b0;
        end else begin
            pixel_out_valid <= rd_en;
        end
    end

    assign pixel_out = bank_quad;

    ////////////////////////////////////////////////////////////
    // Saved pair
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            saved_even <= '0;
            saved_odd  <= '0;
        end else if (save && pixel_out_valid) begin
            if (save_sel == SAVE_ODD_PAIR) begin
                saved_even <= bank_quad.p1;
                saved_odd  <= bank_quad.p3;
            end else begin
                saved_even <= bank_quad.p0;
                saved_odd  <= bank_quad.p2;
            end
        end
    end

endmodule

// ==== rowbuf/rowbuf_top.sv ====
`timescale 1ns/1ps

module rowbuf_top (
    input  logic                       clk,
    input  logic                       rst,
    input  awe_ctrl_pkg::mode_t        mode,
    input  logic [1:0]                 gray_code,
    // Priming
    input  logic [1:0]                 prime_row,
    input  awe_data_pkg::col_t         prime_col,
    input  awe_data_pkg::col_t         num_cols,
    input  logic                       pixel_valid,
    input  awe_data_pkg::pixel_t       pixel_in,
    // Active mode
    input  awe_data_pkg::seq_word_t    seq,
    input  logic                       seq_valid,
    input  logic                       save,
    input  logic                       shift,
    input  awe_data_pkg::col_t         shift_col,
    // Output quad
    output awe_data_pkg::pixel_quad_t  pixel_out,
    output logic                       pixel_out_valid
);

    import awe_data_pkg::*;
    import awe_ctrl_pkg::*;

    bank_wr_vec_t   wr_cmd;
    bank_addr_vec_t rd_addr;
    logic           rd_en;
    save_sel_t      save_sel;
    pixel_quad_t    bank_quad;
    pixel_t         saved_even;
    pixel_t         saved_odd;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////
    rowbuf_addr_decode u_decode (
        .mode        (mode),
        .gray_code   (gray_code),
        .prime_row   (prime_row),
        .prime_col   (prime_col),
        .num_cols    (num_cols),
        .pixel_valid (pixel_valid),
        .seq         (seq),
        .seq_valid   (seq_valid),
        .shift       (shift),
        .shift_col   (shift_col),
        .wr_cmd      (wr_cmd),
        .rd_addr     (rd_addr),
        .rd_en       (rd_en),
        .save_sel    (save_sel)
    );

    ////////////////////////////////////////////////////////////
    // Banks
    ////////////////////////////////////////////////////////////
    rowbuf_bank_array u_banks (
        .clk        (clk),
        .wr_cmd     (wr_cmd),
        .rd_addr    (rd_addr),
        .rd_en      (rd_en),
        .pixel_in   (pixel_in),
        .saved_even (saved_even),
        .saved_odd  (saved_odd),
        .bank_quad  (bank_quad)
    );

    ////////////////////////////////////////////////////////////
    // Output and save registers
    ////////////////////////////////////////////////////////////
    rowbuf_result u_result (
        .clk             (clk),
        .rst             (rst),
        .rd_en           (rd_en),
        .save            (save),
        .save_sel        (save_sel),
        .bank_quad       (bank_quad),
        .pixel_out       (pixel_out),
        .pixel_out_valid (pixel_out_valid),
        .saved_even      (saved_even),
        .saved_odd       (saved_odd)
    );

endmodule

// ==== tb/rowbuf_chk.sv ====
`timescale 1ns/1ps

module rowbuf_chk (
    input  logic                  clk,
    input  logic                  rst,
    input  awe_ctrl_pkg::mode_t   mode,
    input  logic                  seq_valid,
    input  logic                  pixel_out_valid,
    input  awe_data_pkg::pixel_t  saved_even,
    input  awe_data_pkg::pixel_t  saved_odd
);

    import awe_ctrl_pkg::*;

    int   fail_count = 0;
    logic rd_strobe;

    // A read is accepted only in active mode
    assign rd_strobe = (mode == MODE_ACTIVE) && seq_valid;

    ////////////////////////////////////////////////////////////
    // Output valid timing
    ////////////////////////////////////////////////////////////
    a_valid_after_read : assert property (
        @(posedge clk) disable iff (rst) rd_strobe |=> pixel_out_valid
    ) else begin
        $error("pixel_out_valid low one cycle after a read strobe");
        fail_count++;
    end

    a_no_valid_without_read : assert property (
        @(posedge clk) disable iff (rst) !rd_strobe |=> !pixel_out_valid
    ) else begin
        $error("pixel_out_valid high without a read strobe one cycle earlier");
        fail_count++;
    end

    // Read strobes in idle mode are ignored
    a_idle_no_valid : assert property (
        @(posedge clk) disable iff (rst) (mode == MODE_IDLE) |=> !pixel_out_valid
    ) else begin
        $error("pixel_out_valid high after an idle cycle");
        fail_count++;
    end

    a_reset_clears : assert property (
        @(posedge clk) rst |=> (!pixel_out_valid && saved_even == '0 && saved_odd == '0)
    ) else begin
        $error("valid or saved pair not cleared by reset");
        fail_count++;
    end

endmodule

bind rowbuf_top rowbuf_chk chk_i (
    .clk             (clk),
    .rst             (rst),
    .mode            (mode),
    .seq_valid       (seq_valid),
    .pixel_out_valid (pixel_out_valid),
    .saved_even      (saved_even),
    .saved_odd       (saved_odd)
);

// ==== tb/rowbuf_tb.sv ====
`timescale 1ns/1ps

`include "awe_settings.svh"

module rowbuf_tb;

    import awe_data_pkg::*;
    import awe_ctrl_pkg::*;

    localparam int HALF = 1 << `AWE_COL_WIDTH;
    // Sequence below needs about 300 cycles
    localparam int MAX_CYCLES = 600;

    logic        clk = 1'b0;
    logic        rst;
    mode_t       mode;
    logic [1:0]  gray_code;
    logic [1:0]  prime_row;
    col_t        prime_col;
    col_t        num_cols;
    logic        pixel_valid;
    pixel_t      pixel_in;
    seq_word_t   seq;
    logic        seq_valid;
    logic        save;
    logic        shift;
    col_t        shift_col;
    pixel_quad_t pixel_out;
    logic        pixel_out_valid;

    // Reference model of banks, saved pair and output stage
    pixel_t      bank_model [NUM_BANKS][2*HALF];
    pixel_t      model_even = '0;
    pixel_t      model_odd = '0;
    pixel_quad_t out_quad;
    logic        out_valid = 1'b0;
    pixel_quad_t expect_q [$];
    logic [31:0] lcg_state = 32'd45821;
    int          cycle_count = 0;

    rowbuf_top dut_i (
        .clk (clk), .rst (rst), .mode (mode), .gray_code (gray_code),
        .prime_row (prime_row), .prime_col (prime_col), .num_cols (num_cols),
        .pixel_valid (pixel_valid), .pixel_in (pixel_in),
        .seq (seq), .seq_valid (seq_valid), .save (save), .shift (shift),
        .shift_col (shift_col), .pixel_out (pixel_out), .pixel_out_valid (pixel_out_valid)
    );

    always #50 clk = ~clk;

    function automatic pixel_t next_pixel();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31 -: `AWE_PIXEL_WIDTH];
    endfunction

    task automatic fail_now();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    ////////////////////////////////////////////////////////////
    // Model of one clock edge
    ////////////////////////////////////////////////////////////
    task automatic model_cycle();
        pixel_quad_t rd_quad;
        logic        par;
        logic        he;
        logic        ho;
        logic        rd_now;
        int          a;
        par    = gray_code[0] ^ gray_code[1];
        he     = seq.row_sel ^ gray_code[0];
        ho     = seq.row_sel ^ gray_code[1];
        rd_now = (mode == MODE_ACTIVE) && seq_valid;
        // Read sees contents from before this edge
        rd_quad.p0 = bank_model[0][{he, seq.col_even}];
        rd_quad.p2 = bank_model[2][{he, seq.col_even}];
        rd_quad.p1 = bank_model[1][{ho, seq.col_odd}];
        rd_quad.p3 = bank_model[3][{ho, seq.col_odd}];
        if (mode == MODE_PRIME && pixel_valid && prime_col <= num_cols) begin
            a = prime_col;
            if (prime_row == 2'd0) begin
                for (int b = 0; b < NUM_BANKS; b++) bank_model[b][a] = pixel_in;
            end else if (prime_row == 2'd1) begin
                bank_model[1][a + HALF] = pixel_in;
                bank_model[3][a + HALF] = pixel_in;
            end else if (prime_row == 2'd2) begin
                bank_model[0][a + HALF] = pixel_in;
                bank_model[2][a + HALF] = pixel_in;
            end
        end else if (mode == MODE_ACTIVE && shift) begin
            a = shift_col;
            if (!par) begin
                bank_model[1][a] = pixel_in;
                bank_model[3][a] = pixel_in;
                bank_model[0][a] = model_even;
                bank_model[2][a] = model_odd;
            end else begin
                bank_model[0][a] = pixel_in;
                bank_model[2][a] = pixel_in;
                bank_model[1][a] = model_even;
                bank_model[3][a] = model_odd;
            end
        end
        // Saved pair loads after the shift has used the old values
        if (save && out_valid) begin
            model_even = par ? out_quad.p0 : out_quad.p1;
            model_odd  = par ? out_quad.p2 : out_quad.p3;
        end
        out_valid = rd_now;
        if (rd_now) begin
            out_quad = rd_quad;
            expect_q.push_back(rd_quad);
        end
    endtask

    task automatic tick();
        model_cycle();
        @(posedge clk);
        #1;
        seq_valid   = 1'b0;
        pixel_valid = 1'b0;
        save        = 1'b0;
        shift       = 1'b0;
    endtask

    task automatic prime_rows(col_t limit, int first_col);
        for (int r = 0; r < 3; r++) begin
            for (int c = first_col; c < HALF; c++) begin
                mode        = MODE_PRIME;
                num_cols    = limit;
                prime_row   = 2'(r);
                prime_col   = col_t'(c);
                pixel_valid = 1'b1;
                pixel_in    = next_pixel();
                tick();
            end
        end
    endtask

    task automatic read_all(logic [1:0] gc);
        for (int c = 0; c < HALF; c++) begin
            mode      = MODE_ACTIVE;
            gray_code = gc;
            seq       = '{row_sel: c[0], col_even: col_t'(c), col_odd: col_t'(HALF - 1 - c)};
            seq_valid = 1'b1;
            tick();
        end
    endtask

    task automatic read_col(col_t col);
        for (int h = 0; h < 2; h++) begin
            mode      = MODE_ACTIVE;
            seq       = '{row_sel: h[0], col_even: col, col_odd: col};
            seq_valid = 1'b1;
            tick();
        end
    endtask

    task automatic save_and_shift(logic [1:0] gc, col_t col);
        mode      = MODE_ACTIVE;
        gray_code = gc;
        seq       = '{row_sel: 1'b0, col_even: col, col_odd: col};
        seq_valid = 1'b1;
        tick();
        // Output of that read is valid in this cycle
        save = 1'b1;
        tick();
        shift     = 1'b1;
        shift_col = col;
        pixel_in  = next_pixel();
        tick();
        read_col(col);
    endtask

    // Compare outputs in the middle of the cycle
    always @(negedge clk) begin
        pixel_quad_t expected;
        if (dut_i.chk_i.fail_count != 0) begin
            $display("A timing assertion in rowbuf_chk failed at %0t", $time);
            fail_now();
        end
        if (pixel_out_valid) begin
            if (expect_q.size() == 0) begin
                $display("Output valid at %0t with no read outstanding", $time);
                fail_now();
            end
            expected = expect_q.pop_front();
            assert (pixel_out === expected) else begin
                $display("** Error at %0t: pixel_out expected %h, actual %h",
                         $time, expected, pixel_out);
                fail_now();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            fail_now();
        end
    end

    initial begin
        rst = 1'b1;
        mode = MODE_IDLE;
        gray_code = 2'b00;
        prime_row = 2'd0;
        prime_col = '0;
        num_cols = '0;
        pixel_valid = 1'b0;
        pixel_in = '0;
        seq = '0;
        seq_valid = 1'b0;
        save = 1'b0;
        shift = 1'b0;
        shift_col = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // Idle read strobes
        for (int i = 0; i < 4; i++) begin
            seq_valid = 1'b1;
            tick();
        end
        // Background for columns past the limit, then the limited prime
        prime_rows(col_t'(HALF - 1), 21);
        prime_rows(col_t'(20), 0);
        read_all(2'b00);
        read_all(2'b01);
        read_all(2'b10);
        read_all(2'b11);
        save_and_shift(2'b00, col_t'(5));
        save_and_shift(2'b01, col_t'(9));
        save_and_shift(2'b11, col_t'(14));
        save_and_shift(2'b10, col_t'(2));
        // Writes outside their modes
        mode = MODE_IDLE;
        prime_row = 2'd0;
        prime_col = col_t'(3);
        num_cols = col_t'(20);
        pixel_valid = 1'b1;
        pixel_in = next_pixel();
        tick();
        mode = MODE_PRIME;
        shift = 1'b1;
        shift_col = col_t'(3);
        pixel_in = next_pixel();
        tick();
        mode = MODE_IDLE;
        shift = 1'b1;
        tick();
        gray_code = 2'b00;
        read_col(col_t'(3));
        mode = MODE_IDLE;
        while (expect_q.size() != 0) tick();
        tick();
        if (dut_i.chk_i.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("A timing assertion in rowbuf_chk failed in the last cycle");
            fail_now();
        end
    end

endmodule

// ==== sim.f ====
+incdir+common
common/awe_data_pkg.sv
common/awe_ctrl_pkg.sv
logic/pixel_ram.sv
rowbuf/rowbuf_addr_decode.sv
rowbuf/rowbuf_bank_array.sv
rowbuf/rowbuf_result.sv
rowbuf/rowbuf_top.sv
tb/rowbuf_chk.sv
tb/rowbuf_tb.sv

// ==== Bender.yml ====
package:
  name: rowbuf

sources:
  - include_dirs:
      - common
    files:
      - common/awe_data_pkg.sv
      - common/awe_ctrl_pkg.sv
      - logic/pixel_ram.sv
      - rowbuf/rowbuf_addr_decode.sv
      - rowbuf/rowbuf_bank_array.sv
      - rowbuf/rowbuf_result.sv
      - rowbuf/rowbuf_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/rowbuf_chk.sv
      - tb/rowbuf_tb.sv
